/* Bender.yml */
package:
  name: bypass_unit

sources:
  - hw/coreParamsPkg.sv
  - hw/bypassPkg.sv
  - hw/bypassTagPipe.sv
  - hw/bypassSelect.sv
  - hw/bypassController.sv
  - hw/bypassNetwork.sv
  - hw/bypassUnit.sv
  - target: test
    files:
      - verification/bypassModel.sv
      - verification/bypassUnitTb.sv

/* hw/bypassController.sv */
// Bypass controller for the RR stage

module bypassController
    import coreParamsPkg::*;
    import bypassPkg::*;
(
    input  logic       clk,
    input  logic       rstN,
    input  logic       stall,
    input  logic       clear,
    input  pRegNum     intDstRegNum   [INT_ISSUE_WIDTH],
    input  logic       intWriteReg    [INT_ISSUE_WIDTH],
    input  pRegNum     memDstRegNum   [LOAD_ISSUE_WIDTH],
    input  logic       memWriteReg    [LOAD_ISSUE_WIDTH],
    input  pRegNum     intSrcRegNumA  [INT_ISSUE_WIDTH],
    input  pRegNum     intSrcRegNumB  [INT_ISSUE_WIDTH],
    input  logic       intReadRegA    [INT_ISSUE_WIDTH],
    input  logic       intReadRegB    [INT_ISSUE_WIDTH],
    input  pRegNum     memSrcRegNumA  [MEM_ISSUE_WIDTH],
    input  pRegNum     memSrcRegNumB  [MEM_ISSUE_WIDTH],
    input  logic       memReadRegA    [MEM_ISSUE_WIDTH],
    input  logic       memReadRegB    [MEM_ISSUE_WIDTH],
    output logic       intSelValidA   [INT_ISSUE_WIDTH],
    output bypassStage intSelStageA   [INT_ISSUE_WIDTH],
    output intLaneIdx  intSelIntLaneA [INT_ISSUE_WIDTH],
    output memLaneIdx  intSelMemLaneA [INT_ISSUE_WIDTH],
    output logic       intSelValidB   [INT_ISSUE_WIDTH],
    output bypassStage intSelStageB   [INT_ISSUE_WIDTH],
    output intLaneIdx  intSelIntLaneB [INT_ISSUE_WIDTH],
    output memLaneIdx  intSelMemLaneB [INT_ISSUE_WIDTH],
    output logic       memSelValidA   [MEM_ISSUE_WIDTH],
    output bypassStage memSelStageA   [MEM_ISSUE_WIDTH],
    output intLaneIdx  memSelIntLaneA [MEM_ISSUE_WIDTH],
    output memLaneIdx  memSelMemLaneA [MEM_ISSUE_WIDTH],
    output logic       memSelValidB   [MEM_ISSUE_WIDTH],
    output bypassStage memSelStageB   [MEM_ISSUE_WIDTH],
    output intLaneIdx  memSelIntLaneB [MEM_ISSUE_WIDTH],
    output memLaneIdx  memSelMemLaneB [MEM_ISSUE_WIDTH]
);

    // Taps shared by every selector
    pRegNum intExRegNum [INT_ISSUE_WIDTH];
    logic   intExWrite  [INT_ISSUE_WIDTH];
    pRegNum intWbRegNum [INT_ISSUE_WIDTH];
    logic   intWbWrite  [INT_ISSUE_WIDTH];
    pRegNum memMaRegNum [LOAD_ISSUE_WIDTH];
    logic   memMaWrite  [LOAD_ISSUE_WIDTH];
    pRegNum memWbRegNum [LOAD_ISSUE_WIDTH];
    logic   memWbWrite  [LOAD_ISSUE_WIDTH];

    // Int: RR EX WB
    for (genvar i = 0; i < INT_ISSUE_WIDTH; i++) begin : gIntPipe
        pRegNum tapRegNum [INT_TAG_DEPTH];
        logic   tapWrite  [INT_TAG_DEPTH];

        bypassTagPipe #(.depth(INT_TAG_DEPTH)) tagPipe (
            .clk, .rstN, .stall, .clear,
            .dstRegNum(intDstRegNum[i]),
            .writeReg (intWriteReg[i]),
            .tapRegNum,
            .tapWrite
        );

        assign intExRegNum[i] = tapRegNum[0];
        assign intExWrite[i]  = tapWrite[0];
        assign intWbRegNum[i] = tapRegNum[INT_TAG_DEPTH-1];
        assign intWbWrite[i]  = tapWrite[INT_TAG_DEPTH-1];
    end

    // Mem: RR EX MT MA WB, only MA and WB carry data
    for (genvar i = 0; i < LOAD_ISSUE_WIDTH; i++) begin : gMemPipe
        pRegNum tapRegNum [MEM_TAG_DEPTH];
        logic   tapWrite  [MEM_TAG_DEPTH];

        bypassTagPipe #(.depth(MEM_TAG_DEPTH)) tagPipe (
            .clk, .rstN, .stall, .clear,
            .dstRegNum(memDstRegNum[i]),
            .writeReg (memWriteReg[i]),
            .tapRegNum,
            .tapWrite
        );

        assign memMaRegNum[i] = tapRegNum[MEM_TAG_DEPTH-2];
        assign memMaWrite[i]  = tapWrite[MEM_TAG_DEPTH-2];
        assign memWbRegNum[i] = tapRegNum[MEM_TAG_DEPTH-1];
        assign memWbWrite[i]  = tapWrite[MEM_TAG_DEPTH-1];
    end

    for (genvar i = 0; i < INT_ISSUE_WIDTH; i++) begin : gIntSel
        bypassSelect selA (
            .srcRegNum(intSrcRegNumA[i]), .readReg(intReadRegA[i]),
            .intExRegNum, .intExWrite, .intWbRegNum, .intWbWrite,
            .memMaRegNum, .memMaWrite, .memWbRegNum, .memWbWrite,
            .selValid(intSelValidA[i]), .selStage(intSelStageA[i]),
            .selIntLane(intSelIntLaneA[i]), .selMemLane(intSelMemLaneA[i])
        );
        bypassSelect selB (
            .srcRegNum(intSrcRegNumB[i]), .readReg(intReadRegB[i]),
            .intExRegNum, .intExWrite, .intWbRegNum, .intWbWrite,
            .memMaRegNum, .memMaWrite, .memWbRegNum, .memWbWrite,
            .selValid(intSelValidB[i]), .selStage(intSelStageB[i]),
            .selIntLane(intSelIntLaneB[i]), .selMemLane(intSelMemLaneB[i])
        );
    end

    for (genvar i = 0; i < MEM_ISSUE_WIDTH; i++) begin : gMemSel
        bypassSelect selA (
            .srcRegNum(memSrcRegNumA[i]), .readReg(memReadRegA[i]),
            .intExRegNum, .intExWrite, .intWbRegNum, .intWbWrite,
            .memMaRegNum, .memMaWrite, .memWbRegNum, .memWbWrite,
            .selValid(memSelValidA[i]), .selStage(memSelStageA[i]),
            .selIntLane(memSelIntLaneA[i]), .selMemLane(memSelMemLaneA[i])
        );
        bypassSelect selB (
            .srcRegNum(memSrcRegNumB[i]), .readReg(memReadRegB[i]),
            .intExRegNum, .intExWrite, .intWbRegNum, .intWbWrite,
            .memMaRegNum, .memMaWrite, .memWbRegNum, .memWbWrite,
            .selValid(memSelValidB[i]), .selStage(memSelStageB[i]),
            .selIntLane(memSelIntLaneB[i]), .selMemLane(memSelMemLaneB[i])
        );
    end

endmodule

/* hw/bypassNetwork.sv */
// Operand bypass data network into EX

module bypassNetwork
    import coreParamsPkg::*;
    import bypassPkg::*;
(
    input  logic       clk,
    input  logic       rstN,
    input  logic       stall,
    input  logic       clear,
    input  logic       intSelValidA   [INT_ISSUE_WIDTH],
    input  bypassStage intSelStageA   [INT_ISSUE_WIDTH],
    input  intLaneIdx  intSelIntLaneA [INT_ISSUE_WIDTH],
    input  memLaneIdx  intSelMemLaneA [INT_ISSUE_WIDTH],
    input  logic       intSelValidB   [INT_ISSUE_WIDTH],
    input  bypassStage intSelStageB   [INT_ISSUE_WIDTH],
    input  intLaneIdx  intSelIntLaneB [INT_ISSUE_WIDTH],
    input  memLaneIdx  intSelMemLaneB [INT_ISSUE_WIDTH],
    input  logic       memSelValidA   [MEM_ISSUE_WIDTH],
    input  bypassStage memSelStageA   [MEM_ISSUE_WIDTH],
    input  intLaneIdx  memSelIntLaneA [MEM_ISSUE_WIDTH],
    input  memLaneIdx  memSelMemLaneA [MEM_ISSUE_WIDTH],
    input  logic       memSelValidB   [MEM_ISSUE_WIDTH],
    input  bypassStage memSelStageB   [MEM_ISSUE_WIDTH],
    input  intLaneIdx  memSelIntLaneB [MEM_ISSUE_WIDTH],
    input  memLaneIdx  memSelMemLaneB [MEM_ISSUE_WIDTH],
    input  dataWord    intRfDataA     [INT_ISSUE_WIDTH],
    input  dataWord    intRfDataB     [INT_ISSUE_WIDTH],
    input  dataWord    memRfDataA     [MEM_ISSUE_WIDTH],
    input  dataWord    memRfDataB     [MEM_ISSUE_WIDTH],
    input  dataWord    intExResult    [INT_ISSUE_WIDTH],
    input  dataWord    intWbResult    [INT_ISSUE_WIDTH],
    input  dataWord    memMaResult    [LOAD_ISSUE_WIDTH],
    input  dataWord    memWbResult    [LOAD_ISSUE_WIDTH],
    output dataWord    intOperandA    [INT_ISSUE_WIDTH],
    output dataWord    intOperandB    [INT_ISSUE_WIDTH],
    output logic       intBypassedA   [INT_ISSUE_WIDTH],
    output logic       intBypassedB   [INT_ISSUE_WIDTH],
    output dataWord    memOperandA    [MEM_ISSUE_WIDTH],
    output dataWord    memOperandB    [MEM_ISSUE_WIDTH],
    output logic       memBypassedA   [MEM_ISSUE_WIDTH],
    output logic       memBypassedB   [MEM_ISSUE_WIDTH]
);

    localparam int MEM_A_BASE = 2 * INT_ISSUE_WIDTH;
    localparam int MEM_B_BASE = 2 * INT_ISSUE_WIDTH + MEM_ISSUE_WIDTH;

    // All operands in one flat view, int A, int B, mem A, mem B
    logic       selValid [OPERAND_NUM];
    bypassStage selStage [OPERAND_NUM];
    intLaneIdx  selInt   [OPERAND_NUM];
    memLaneIdx  selMem   [OPERAND_NUM];
    dataWord    rfData   [OPERAND_NUM];
    dataWord    operand  [OPERAND_NUM];

    // EX stage snapshot
    logic       liveQ;
    logic       validQ   [OPERAND_NUM];
    bypassStage stageQ   [OPERAND_NUM];
    intLaneIdx  intLaneQ [OPERAND_NUM];
    memLaneIdx  memLaneQ [OPERAND_NUM];
    dataWord    rfQ      [OPERAND_NUM];
    dataWord    intExQ   [INT_ISSUE_WIDTH];
    dataWord    intWbQ   [INT_ISSUE_WIDTH];
    dataWord    memMaQ   [LOAD_ISSUE_WIDTH];
    dataWord    memWbQ   [LOAD_ISSUE_WIDTH];

    always_comb begin
        for (int i = 0; i < INT_ISSUE_WIDTH; i++) begin
            selValid[i] = intSelValidA[i];
            selStage[i] = intSelStageA[i];
            selInt[i]   = intSelIntLaneA[i];
            selMem[i]   = intSelMemLaneA[i];
            rfData[i]   = intRfDataA[i];
            selValid[INT_ISSUE_WIDTH+i] = intSelValidB[i];
            selStage[INT_ISSUE_WIDTH+i] = intSelStageB[i];
            selInt[INT_ISSUE_WIDTH+i]   = intSelIntLaneB[i];
            selMem[INT_ISSUE_WIDTH+i]   = intSelMemLaneB[i];
            rfData[INT_ISSUE_WIDTH+i]   = intRfDataB[i];
        end
        for (int i = 0; i < MEM_ISSUE_WIDTH; i++) begin
            selValid[MEM_A_BASE+i] = memSelValidA[i];
            selStage[MEM_A_BASE+i] = memSelStageA[i];
            selInt[MEM_A_BASE+i]   = memSelIntLaneA[i];
            selMem[MEM_A_BASE+i]   = memSelMemLaneA[i];
            rfData[MEM_A_BASE+i]   = memRfDataA[i];
            selValid[MEM_B_BASE+i] = memSelValidB[i];
            selStage[MEM_B_BASE+i] = memSelStageB[i];
            selInt[MEM_B_BASE+i]   = memSelIntLaneB[i];
            selMem[MEM_B_BASE+i]   = memSelMemLaneB[i];
            rfData[MEM_B_BASE+i]   = memRfDataB[i];
        end
    end

    // liveQ low forces zero operands until the next capture
    always_ff @(posedge clk or negedge rstN) begin
        if (!rstN) begin
            liveQ <= 1'b0;
            for (int i = 0; i < OPERAND_NUM; i++) begin
                validQ[i] <= 1'b0;
            end
        end else if (clear) begin
            liveQ <= 1'b0;
            for (int i = 0; i < OPERAND_NUM; i++) begin
                validQ[i] <= 1'b0;
            end
        end else if (!stall) begin
            liveQ  <= 1'b1;
            validQ <= selValid;
        end
    end

    always_ff @(posedge clk) begin
        if (!stall) begin
            stageQ   <= selStage;
            intLaneQ <= selInt;
            memLaneQ <= selMem;
            rfQ      <= rfData;
            intExQ   <= intExResult;
            intWbQ   <= intWbResult;
            memMaQ   <= memMaResult;
            memWbQ   <= memWbResult;
        end
    end

    always_comb begin
        for (int i = 0; i < OPERAND_NUM; i++) begin
            if (!liveQ) begin
                operand[i] = '0;
            end else if (!validQ[i]) begin
                operand[i] = rfQ[i];
            end else begin
                case (stageQ[i])
                    BYPASS_STAGE_INT_EX: operand[i] = intExQ[intLaneQ[i]];
                    BYPASS_STAGE_INT_WB: operand[i] = intWbQ[intLaneQ[i]];
                    BYPASS_STAGE_MEM_MA: operand[i] = memMaQ[memLaneQ[i]];
                    default:             operand[i] = memWbQ[memLaneQ[i]];
                endcase
            end
        end
    end

    always_comb begin
        for (int i = 0; i < INT_ISSUE_WIDTH; i++) begin
            intOperandA[i]  = operand[i];
            intBypassedA[i] = validQ[i];
            intOperandB[i]  = operand[INT_ISSUE_WIDTH+i];
            intBypassedB[i] = validQ[INT_ISSUE_WIDTH+i];
        end
        for (int i = 0; i < MEM_ISSUE_WIDTH; i++) begin
            memOperandA[i]  = operand[MEM_A_BASE+i];
            memBypassedA[i] = validQ[MEM_A_BASE+i];
            memOperandB[i]  = operand[MEM_B_BASE+i];
            memBypassedB[i] = validQ[MEM_B_BASE+i];
        end
    end

    for (genvar i = 0; i < OPERAND_NUM; i++) begin : gStageCheck
        stageKnown : assert property (
            @(posedge clk) disable iff (!rstN) validQ[i] |-> !$isunknown(stageQ[i])
        );
    end

endmodule

/* hw/bypassPkg.sv */
// Bypass stage codes and tag pipeline depths

package bypassPkg;
    import coreParamsPkg::*;

    // Producer stage that a select points at
    localparam int BYPASS_STAGE_WIDTH = 2;
    typedef logic [BYPASS_STAGE_WIDTH-1:0] bypassStage;

    localparam bypassStage BYPASS_STAGE_INT_EX = 2'd0;
    localparam bypassStage BYPASS_STAGE_INT_WB = 2'd1;
    localparam bypassStage BYPASS_STAGE_MEM_MA = 2'd2;
    localparam bypassStage BYPASS_STAGE_MEM_WB = 2'd3;

    // Lane indices, at least one bit each
    localparam int INT_LANE_IDX_WIDTH = 1;
    typedef logic [INT_LANE_IDX_WIDTH-1:0] intLaneIdx;

    localparam int MEM_LANE_IDX_WIDTH = 1;
    typedef logic [MEM_LANE_IDX_WIDTH-1:0] memLaneIdx;

    // Integer taps are EX and WB
    localparam int INT_TAG_DEPTH = 2;
    // Load taps are EX, MT, MA and WB
    localparam int MEM_TAG_DEPTH = 4;

    // Operands A and B of every consumer lane
    localparam int OPERAND_NUM = 2 * (INT_ISSUE_WIDTH + MEM_ISSUE_WIDTH);

endpackage

/* hw/bypassSelect.sv */
// Source operand priority matcher

module bypassSelect
    import coreParamsPkg::*;
    import bypassPkg::*;
(
    input  pRegNum     srcRegNum,
    input  logic       readReg,
    input  pRegNum     intExRegNum [INT_ISSUE_WIDTH],
    input  logic       intExWrite  [INT_ISSUE_WIDTH],
    input  pRegNum     intWbRegNum [INT_ISSUE_WIDTH],
    input  logic       intWbWrite  [INT_ISSUE_WIDTH],
    input  pRegNum     memMaRegNum [LOAD_ISSUE_WIDTH],
    input  logic       memMaWrite  [LOAD_ISSUE_WIDTH],
    input  pRegNum     memWbRegNum [LOAD_ISSUE_WIDTH],
    input  logic       memWbWrite  [LOAD_ISSUE_WIDTH],
    output logic       selValid,
    output bypassStage selStage,
    output intLaneIdx  selIntLane,
    output memLaneIdx  selMemLane
);

    logic intHit;
    logic memHit;
    logic selTapHit;

    always_comb begin
        intHit     = 1'b0;
        memHit     = 1'b0;
        selStage   = BYPASS_STAGE_INT_EX;
        selIntLane = '0;
        selMemLane = '0;

        // Lowest integer lane first and EX before WB
        for (int i = 0; i < INT_ISSUE_WIDTH; i++) begin
            if (!intHit) begin
                if (readReg && intExWrite[i] && srcRegNum == intExRegNum[i]) begin
                    intHit     = 1'b1;
                    selStage   = BYPASS_STAGE_INT_EX;
                    selIntLane = intLaneIdx'(i);
                end else if (readReg && intWbWrite[i] && srcRegNum == intWbRegNum[i]) begin
                    intHit     = 1'b1;
                    selStage   = BYPASS_STAGE_INT_WB;
                    selIntLane = intLaneIdx'(i);
                end
            end
        end

        // A load producer wins over any integer match
        for (int i = 0; i < LOAD_ISSUE_WIDTH; i++) begin
            if (!memHit) begin
                if (readReg && memMaWrite[i] && srcRegNum == memMaRegNum[i]) begin
                    memHit     = 1'b1;
                    selStage   = BYPASS_STAGE_MEM_MA;
                    selMemLane = memLaneIdx'(i);
                end else if (readReg && memWbWrite[i] && srcRegNum == memWbRegNum[i]) begin
                    memHit     = 1'b1;
                    selStage   = BYPASS_STAGE_MEM_WB;
                    selMemLane = memLaneIdx'(i);
                end
            end
        end

        selValid = intHit || memHit;
    end

    // Tap named by the select fields, looked up again
    always_comb begin
        case (selStage)
            BYPASS_STAGE_INT_EX: begin
                selTapHit = intExWrite[selIntLane] && intExRegNum[selIntLane] == srcRegNum;
            end
            BYPASS_STAGE_INT_WB: begin
                selTapHit = intWbWrite[selIntLane] && intWbRegNum[selIntLane] == srcRegNum;
            end
            BYPASS_STAGE_MEM_MA: begin
                selTapHit = memMaWrite[selMemLane] && memMaRegNum[selMemLane] == srcRegNum;
            end
            default: begin
                selTapHit = memWbWrite[selMemLane] && memWbRegNum[selMemLane] == srcRegNum;
            end
        endcase
    end

    always_comb begin
        selNeedsRead : assert final (!selValid || (readReg && selTapHit));
    end

endmodule

/* hw/bypassTagPipe.sv */
// Destination tag delay chain

module bypassTagPipe
    import coreParamsPkg::*;
#(
    parameter int depth = 2
) (
    input  logic   clk,
    input  logic   rstN,
    input  logic   stall,
    input  logic   clear,
    input  pRegNum dstRegNum,
    input  logic   writeReg,
    output pRegNum tapRegNum [depth],
    output logic   tapWrite  [depth]
);

    pRegNum regNumQ [depth];
    logic   writeQ  [depth];

    // Valid bits empty on reset or clear
    always_ff @(posedge clk or negedge rstN) begin
        if (!rstN) begin
            for (int i = 0; i < depth; i++) begin
                writeQ[i] <= 1'b0;
            end
        end else if (clear) begin
            for (int i = 0; i < depth; i++) begin
                writeQ[i] <= 1'b0;
            end
        end else if (!stall) begin
            writeQ[0] <= writeReg;
            for (int i = 1; i < depth; i++) begin
                writeQ[i] <= writeQ[i-1];
            end
        end
    end

    // Register numbers only matter while their valid bit is set
    always_ff @(posedge clk) begin
        if (!stall) begin
            regNumQ[0] <= dstRegNum;
            for (int i = 1; i < depth; i++) begin
                regNumQ[i] <= regNumQ[i-1];
            end
        end
    end

    assign tapRegNum = regNumQ;
    assign tapWrite  = writeQ;

    for (genvar i = 0; i < depth; i++) begin : gTapCheck
        tapWriteKnown : assert property (
            @(posedge clk) disable iff (!rstN) !$isunknown(tapWrite[i])
        );
    end

endmodule

/* hw/bypassUnit.sv */
// Operand bypass unit

module bypassUnit
    import coreParamsPkg::*;
    import bypassPkg::*;
(
    input  logic    clk,
    input  logic    rstN,
    input  logic    stall,
    input  logic    clear,
    input  pRegNum  intDstRegNum  [INT_ISSUE_WIDTH],
    input  logic    intWriteReg   [INT_ISSUE_WIDTH],
    input  pRegNum  memDstRegNum  [LOAD_ISSUE_WIDTH],
    input  logic    memWriteReg   [LOAD_ISSUE_WIDTH],
    input  pRegNum  intSrcRegNumA [INT_ISSUE_WIDTH],
    input  pRegNum  intSrcRegNumB [INT_ISSUE_WIDTH],
    input  logic    intReadRegA   [INT_ISSUE_WIDTH],
    input  logic    intReadRegB   [INT_ISSUE_WIDTH],
    input  dataWord intRfDataA    [INT_ISSUE_WIDTH],
    input  dataWord intRfDataB    [INT_ISSUE_WIDTH],
    input  pRegNum  memSrcRegNumA [MEM_ISSUE_WIDTH],
    input  pRegNum  memSrcRegNumB [MEM_ISSUE_WIDTH],
    input  logic    memReadRegA   [MEM_ISSUE_WIDTH],
    input  logic    memReadRegB   [MEM_ISSUE_WIDTH],
    input  dataWord memRfDataA    [MEM_ISSUE_WIDTH],
    input  dataWord memRfDataB    [MEM_ISSUE_WIDTH],
    input  dataWord intExResult   [INT_ISSUE_WIDTH],
    input  dataWord intWbResult   [INT_ISSUE_WIDTH],
    input  dataWord memMaResult   [LOAD_ISSUE_WIDTH],
    input  dataWord memWbResult   [LOAD_ISSUE_WIDTH],
    output dataWord intOperandA   [INT_ISSUE_WIDTH],
    output dataWord intOperandB   [INT_ISSUE_WIDTH],
    output logic    intBypassedA  [INT_ISSUE_WIDTH],
    output logic    intBypassedB  [INT_ISSUE_WIDTH],
    output dataWord memOperandA   [MEM_ISSUE_WIDTH],
    output dataWord memOperandB   [MEM_ISSUE_WIDTH],
    output logic    memBypassedA  [MEM_ISSUE_WIDTH],
    output logic    memBypassedB  [MEM_ISSUE_WIDTH]
);

    // Select fields from RR into the network
    logic       intSelValidA   [INT_ISSUE_WIDTH];
    bypassStage intSelStageA   [INT_ISSUE_WIDTH];
    intLaneIdx  intSelIntLaneA [INT_ISSUE_WIDTH];
    memLaneIdx  intSelMemLaneA [INT_ISSUE_WIDTH];
    logic       intSelValidB   [INT_ISSUE_WIDTH];
    bypassStage intSelStageB   [INT_ISSUE_WIDTH];
    intLaneIdx  intSelIntLaneB [INT_ISSUE_WIDTH];
    memLaneIdx  intSelMemLaneB [INT_ISSUE_WIDTH];
    logic       memSelValidA   [MEM_ISSUE_WIDTH];
    bypassStage memSelStageA   [MEM_ISSUE_WIDTH];
    intLaneIdx  memSelIntLaneA [MEM_ISSUE_WIDTH];
    memLaneIdx  memSelMemLaneA [MEM_ISSUE_WIDTH];
    logic       memSelValidB   [MEM_ISSUE_WIDTH];
    bypassStage memSelStageB   [MEM_ISSUE_WIDTH];
    intLaneIdx  memSelIntLaneB [MEM_ISSUE_WIDTH];
    memLaneIdx  memSelMemLaneB [MEM_ISSUE_WIDTH];

    bypassController controller (.*);

    bypassNetwork network (.*);

endmodule

/* hw/coreParamsPkg.sv */
// Core widths and lane counts

package coreParamsPkg;

    // Issue lanes of the back end
    localparam int INT_ISSUE_WIDTH = 2;
    localparam int LOAD_ISSUE_WIDTH = 1;

    // Memory consumers share the load lane
    localparam int MEM_ISSUE_WIDTH = 1;

    // Physical register number
    localparam int PREG_NUM_WIDTH = 6;
    typedef logic [PREG_NUM_WIDTH-1:0] pRegNum;

    // Operand word
    localparam int DATA_WIDTH = 32;
    typedef logic [DATA_WIDTH-1:0] dataWord;

endpackage

/* list.f */
hw/coreParamsPkg.sv
hw/bypassPkg.sv
hw/bypassTagPipe.sv
hw/bypassSelect.sv
hw/bypassController.sv
hw/bypassNetwork.sv
hw/bypassUnit.sv
verification/bypassModel.sv
verification/bypassUnitTb.sv

/* verification/bypassModel.sv */
// Reference model of the bypass unit

module bypassModel
    import coreParamsPkg::*;
    import bypassPkg::*;
(
    input  logic    clk,
    input  logic    rstN,
    input  logic    stall,
    input  logic    clear,
    input  pRegNum  intDst      [INT_ISSUE_WIDTH],
    input  logic    intWr       [INT_ISSUE_WIDTH],
    input  pRegNum  memDst      [LOAD_ISSUE_WIDTH],
    input  logic    memWr       [LOAD_ISSUE_WIDTH],
    input  pRegNum  src         [OPERAND_NUM],
    input  logic    rd          [OPERAND_NUM],
    input  dataWord rf          [OPERAND_NUM],
    input  dataWord intEx       [INT_ISSUE_WIDTH],
    input  dataWord intWb       [INT_ISSUE_WIDTH],
    input  dataWord memMa       [LOAD_ISSUE_WIDTH],
    input  dataWord memWb       [LOAD_ISSUE_WIDTH],
    output dataWord expOperand  [OPERAND_NUM],
    output logic    expBypassed [OPERAND_NUM]
);

    localparam int INT_WB_TAP = INT_TAG_DEPTH - 1;
    localparam int MEM_MA_TAP = MEM_TAG_DEPTH - 2;
    localparam int MEM_WB_TAP = MEM_TAG_DEPTH - 1;

    // Tag and valid per lane and stage, index 0 is EX
    pRegNum intTag [INT_ISSUE_WIDTH][INT_TAG_DEPTH];
    logic   intVal [INT_ISSUE_WIDTH][INT_TAG_DEPTH];
    pRegNum memTag [LOAD_ISSUE_WIDTH][MEM_TAG_DEPTH];
    logic   memVal [LOAD_ISSUE_WIDTH][MEM_TAG_DEPTH];

    // Weakest producer first, so every later hit overrides
    function automatic logic [DATA_WIDTH:0] resolve(input int k);
        logic [DATA_WIDTH:0] pick;
        pick = {1'b0, rf[k]};
        if (rd[k]) begin
            for (int lane = INT_ISSUE_WIDTH - 1; lane >= 0; lane--) begin
                if (intVal[lane][INT_WB_TAP] && intTag[lane][INT_WB_TAP] == src[k]) begin
                    pick = {1'b1, intWb[lane]};
                end
                if (intVal[lane][0] && intTag[lane][0] == src[k]) begin
                    pick = {1'b1, intEx[lane]};
                end
            end
            // Loads beat every integer producer
            for (int lane = LOAD_ISSUE_WIDTH - 1; lane >= 0; lane--) begin
                if (memVal[lane][MEM_WB_TAP] && memTag[lane][MEM_WB_TAP] == src[k]) begin
                    pick = {1'b1, memWb[lane]};
                end
                if (memVal[lane][MEM_MA_TAP] && memTag[lane][MEM_MA_TAP] == src[k]) begin
                    pick = {1'b1, memMa[lane]};
                end
            end
        end
        return pick;
    endfunction

    always @(posedge clk or negedge rstN) begin
        logic [DATA_WIDTH:0] pick;
        if (!rstN || clear) begin
            intVal      <= '{default: '{default: 1'b0}};
            memVal      <= '{default: '{default: 1'b0}};
            expOperand  <= '{default: '0};
            expBypassed <= '{default: 1'b0};
        end else if (!stall) begin
            for (int k = 0; k < OPERAND_NUM; k++) begin
                pick = resolve(k);
                expBypassed[k] <= pick[DATA_WIDTH];
                expOperand[k]  <= pick[DATA_WIDTH-1:0];
            end
            for (int lane = 0; lane < INT_ISSUE_WIDTH; lane++) begin
                for (int s = INT_TAG_DEPTH - 1; s > 0; s--) begin
                    intTag[lane][s] <= intTag[lane][s-1];
                    intVal[lane][s] <= intVal[lane][s-1];
                end
                intTag[lane][0] <= intDst[lane];
                intVal[lane][0] <= intWr[lane];
            end
            for (int lane = 0; lane < LOAD_ISSUE_WIDTH; lane++) begin
                for (int s = MEM_TAG_DEPTH - 1; s > 0; s--) begin
                    memTag[lane][s] <= memTag[lane][s-1];
                    memVal[lane][s] <= memVal[lane][s-1];
                end
                memTag[lane][0] <= memDst[lane];
                memVal[lane][0] <= memWr[lane];
            end
        end
    end

endmodule

/* verification/bypassUnitTb.sv */
// Testbench for the operand bypass unit

module bypassUnitTb
    import coreParamsPkg::*;
    import bypassPkg::*;
();

    localparam int RESET_CYCLES   = 16;
    localparam int TEST_CYCLES    = 2000;
    localparam int TIMEOUT_CYCLES = RESET_CYCLES + TEST_CYCLES + 184;
    // Second reset in the middle of the run
    localparam int REPEAT_RESET_AT = 1200;
    localparam int MEM_A_BASE = 2 * INT_ISSUE_WIDTH;
    localparam int MEM_B_BASE = MEM_A_BASE + MEM_ISSUE_WIDTH;

    logic    clk = 1'b0;
    logic    rstN;
    logic    stall;
    logic    clear;
    pRegNum  intDstRegNum [INT_ISSUE_WIDTH];
    logic    intWriteReg  [INT_ISSUE_WIDTH];
    pRegNum  memDstRegNum [LOAD_ISSUE_WIDTH];
    logic    memWriteReg  [LOAD_ISSUE_WIDTH];
    dataWord intExResult  [INT_ISSUE_WIDTH];
    dataWord intWbResult  [INT_ISSUE_WIDTH];
    dataWord memMaResult  [LOAD_ISSUE_WIDTH];
    dataWord memWbResult  [LOAD_ISSUE_WIDTH];

    // Flat operand view in order int A, int B, mem A, mem B
    pRegNum  src         [OPERAND_NUM];
    logic    rd          [OPERAND_NUM];
    dataWord rf          [OPERAND_NUM];
    dataWord gotOperand  [OPERAND_NUM];
    logic    gotBypassed [OPERAND_NUM];
    dataWord expOperand  [OPERAND_NUM];
    logic    expBypassed [OPERAND_NUM];

    pRegNum  intSrcRegNumA [INT_ISSUE_WIDTH];
    pRegNum  intSrcRegNumB [INT_ISSUE_WIDTH];
    logic    intReadRegA   [INT_ISSUE_WIDTH];
    logic    intReadRegB   [INT_ISSUE_WIDTH];
    dataWord intRfDataA    [INT_ISSUE_WIDTH];
    dataWord intRfDataB    [INT_ISSUE_WIDTH];
    pRegNum  memSrcRegNumA [MEM_ISSUE_WIDTH];
    pRegNum  memSrcRegNumB [MEM_ISSUE_WIDTH];
    logic    memReadRegA   [MEM_ISSUE_WIDTH];
    logic    memReadRegB   [MEM_ISSUE_WIDTH];
    dataWord memRfDataA    [MEM_ISSUE_WIDTH];
    dataWord memRfDataB    [MEM_ISSUE_WIDTH];
    dataWord intOperandA   [INT_ISSUE_WIDTH];
    dataWord intOperandB   [INT_ISSUE_WIDTH];
    logic    intBypassedA  [INT_ISSUE_WIDTH];
    logic    intBypassedB  [INT_ISSUE_WIDTH];
    dataWord memOperandA   [MEM_ISSUE_WIDTH];
    dataWord memOperandB   [MEM_ISSUE_WIDTH];
    logic    memBypassedA  [MEM_ISSUE_WIDTH];
    logic    memBypassedB  [MEM_ISSUE_WIDTH];

    int errorCount = 0;
    int checkCount = 0;
    int bypassHits = 0;
    int cycleCount = 0;

    for (genvar i = 0; i < INT_ISSUE_WIDTH; i++) begin : gIntMap
        assign intSrcRegNumA[i] = src[i];
        assign intSrcRegNumB[i] = src[INT_ISSUE_WIDTH+i];
        assign intReadRegA[i]   = rd[i];
        assign intReadRegB[i]   = rd[INT_ISSUE_WIDTH+i];
        assign intRfDataA[i]    = rf[i];
        assign intRfDataB[i]    = rf[INT_ISSUE_WIDTH+i];
        assign gotOperand[i]                  = intOperandA[i];
        assign gotOperand[INT_ISSUE_WIDTH+i]  = intOperandB[i];
        assign gotBypassed[i]                 = intBypassedA[i];
        assign gotBypassed[INT_ISSUE_WIDTH+i] = intBypassedB[i];
    end

    for (genvar i = 0; i < MEM_ISSUE_WIDTH; i++) begin : gMemMap
        assign memSrcRegNumA[i] = src[MEM_A_BASE+i];
        assign memSrcRegNumB[i] = src[MEM_B_BASE+i];
        assign memReadRegA[i]   = rd[MEM_A_BASE+i];
        assign memReadRegB[i]   = rd[MEM_B_BASE+i];
        assign memRfDataA[i]    = rf[MEM_A_BASE+i];
        assign memRfDataB[i]    = rf[MEM_B_BASE+i];
        assign gotOperand[MEM_A_BASE+i]  = memOperandA[i];
        assign gotOperand[MEM_B_BASE+i]  = memOperandB[i];
        assign gotBypassed[MEM_A_BASE+i] = memBypassedA[i];
        assign gotBypassed[MEM_B_BASE+i] = memBypassedB[i];
    end

    bypassUnit dut (.*);

    bypassModel model (
        .clk, .rstN, .stall, .clear,
        .intDst(intDstRegNum), .intWr(intWriteReg),
        .memDst(memDstRegNum), .memWr(memWriteReg),
        .src, .rd, .rf,
        .intEx(intExResult), .intWb(intWbResult),
        .memMa(memMaResult), .memWb(memWbResult),
        .expOperand, .expBypassed
    );

    always #2 clk = ~clk;

    always @(posedge clk) begin
        cycleCount <= cycleCount + 1;
        if (cycleCount >= TIMEOUT_CYCLES) begin
            $display("Run did not finish within %0d cycles", TIMEOUT_CYCLES);
            $display("tests failed");
            $finish;
        end
    end

    function automatic string operandName(input int k);
        if (k < INT_ISSUE_WIDTH) begin
            return $sformatf("intA[%0d]", k);
        end
        if (k < MEM_A_BASE) begin
            return $sformatf("intB[%0d]", k - INT_ISSUE_WIDTH);
        end
        if (k < MEM_B_BASE) begin
            return $sformatf("memA[%0d]", k - MEM_A_BASE);
        end
        return $sformatf("memB[%0d]", k - MEM_B_BASE);
    endfunction

    task automatic compareValue(input string what, input dataWord got, input dataWord expected);
        checkCount++;
        if (got !== expected) begin
            errorCount++;
            $display("ERR %0t %s got %h expected %h", $time, what, got, expected);
        end
    endtask

    task automatic checkOutputs();
        for (int k = 0; k < OPERAND_NUM; k++) begin
            compareValue({operandName(k), " operand"}, gotOperand[k], expOperand[k]);
            compareValue({operandName(k), " bypassed"}, gotBypassed[k], expBypassed[k]);
            if (expBypassed[k] === 1'b1) begin
                bypassHits++;
            end
        end
    endtask

    // Phases of 250 cycles cycling through plain, crowded tag, heavy stall and frequent clear
    task automatic driveCycle(input int cycle);
        int phase;
        int tagMax;
        phase  = (cycle < 0) ? 0 : (cycle / 250) % 4;
        tagMax = (phase == 1) ? 1 : 7;
        for (int i = 0; i < INT_ISSUE_WIDTH; i++) begin
            intDstRegNum[i] = pRegNum'($urandom_range(0, tagMax));
            intWriteReg[i]  = ($urandom_range(0, 3) != 0);
            intExResult[i]  = $urandom();
            intWbResult[i]  = $urandom();
        end
        for (int i = 0; i < LOAD_ISSUE_WIDTH; i++) begin
            memDstRegNum[i] = pRegNum'($urandom_range(0, tagMax));
            memWriteReg[i]  = ($urandom_range(0, 2) != 0);
            memMaResult[i]  = $urandom();
            memWbResult[i]  = $urandom();
        end
        for (int k = 0; k < OPERAND_NUM; k++) begin
            src[k] = pRegNum'($urandom_range(0, tagMax));
            rd[k]  = ($urandom_range(0, 7) != 0);
            rf[k]  = $urandom();
        end
        stall = (phase == 2) ? ($urandom_range(0, 2) == 0) : ($urandom_range(0, 15) == 0);
        clear = (phase == 3) ? ($urandom_range(0, 9) == 0) : ($urandom_range(0, 199) == 0);
    endtask

    initial begin
        void'($urandom(32'hc272));
        rstN = 1'b0;
        driveCycle(-1);
        stall = 1'b0;
        clear = 1'b0;
        repeat (RESET_CYCLES) @(posedge clk);
        #1;
        rstN = 1'b1;
        for (int cycle = 0; cycle < TEST_CYCLES; cycle++) begin
            @(posedge clk);
            #1;
            checkOutputs();
            driveCycle(cycle);
            rstN = !(cycle >= REPEAT_RESET_AT && cycle < REPEAT_RESET_AT + 4);
        end
        if (bypassHits == 0) begin
            errorCount++;
            $display("No operand was forwarded during the run");
        end
        $display("%0d errors in %0d checks, %0d forwarded operands",
                 errorCount, checkCount, bypassHits);
        if (errorCount == 0) begin
            $display("all tests passed");
        end else begin
            $display("tests failed");
        end
        $finish;
    end

endmodule
